// File: Makefile
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f all.f \
		--top-module mips_core_slice_tb -Mdir obj_dir -o tb_sim
	@out="$$(./obj_dir/tb_sim 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir

// File: all.f
+incdir+src
src/mips_pkg.sv
src/mips_ifs.sv
src/cmb_control.sv
src/operand_fetch.sv
src/exec_unit.sv
src/mips_core_slice.sv
tests/mips_core_slice_sva.sv
tests/mips_core_slice_tb.sv

// File: src/cmb_control.sv
`timescale 1ns/1ps

module cmb_control import mips_pkg::*; (
    input  logic [5:0] opcode,
    input  reg_idx_t   rs,
    input  reg_idx_t   rt,
    input  logic [5:0] funct,
    ctrl_if.dec        ctl
);

    always_comb begin
        ctl.alu_op    = ALU_AND;
        ctl.wtg_op    = WTG_PC4;
        ctl.dm_op     = DM_WORD;
        ctl.reg_we    = 1'b1;
        ctl.mem_we    = 1'b0;
        ctl.mem_re    = 1'b0;
        ctl.wreg_sel  = WREG_RT;
        ctl.wdata_sel = WDATA_ALU;
        ctl.aluy_sel  = ALUY_EXTS;
        ctl.trap      = TRAP_NONE;

        case (opcode)
            6'b000000: begin
                ctl.wreg_sel = WREG_RD;
                ctl.aluy_sel = ALUY_RT;
                case (funct)
                    6'b000000: ctl.alu_op = ALU_SLL;
                    6'b000010: ctl.alu_op = ALU_SRL;
                    6'b000011: ctl.alu_op = ALU_SRA;
                    6'b000100: ctl.alu_op = ALU_SLLV;
                    6'b000110: ctl.alu_op = ALU_SRLV;
                    6'b000111: ctl.alu_op = ALU_SRAV;
                    6'b001000: begin                        // jr
                        ctl.wtg_op = WTG_J32;
                        ctl.reg_we = 1'b0;
                    end
                    6'b001100: begin                        // syscall
                        ctl.trap   = TRAP_SYSCALL;
                        ctl.reg_we = 1'b0;
                    end
                    6'b100000: ctl.alu_op = ALU_ADD;        // add
                    6'b100001: ctl.alu_op = ALU_ADD;        // addu
                    6'b100010: ctl.alu_op = ALU_SUB;
                    6'b100011: ctl.alu_op = ALU_SUB;
                    6'b100100: ctl.alu_op = ALU_AND;
                    6'b100101: ctl.alu_op = ALU_OR;
                    6'b100110: ctl.alu_op = ALU_XOR;
                    6'b100111: ctl.alu_op = ALU_NOR;
                    6'b101010: ctl.alu_op = ALU_SLT;
                    6'b101011: ctl.alu_op = ALU_SLTU;
                    default: ;
                endcase
            end

            6'b000001: begin                                // regimm, only bltz/bgez
                if (rt == 5'b00000 || rt == 5'b00001) begin
                    ctl.wtg_op = WTG_BLTZ_BGEZ;
                    ctl.reg_we = 1'b0;
                end
            end
            6'b000010: begin                                // j
                ctl.wtg_op = WTG_J26;
                ctl.reg_we = 1'b0;
            end
            6'b000011: begin                                // jal
                ctl.wtg_op    = WTG_J26;
                ctl.wreg_sel  = WREG_R31;
                ctl.wdata_sel = WDATA_PC4;
            end
            6'b000100: begin
                ctl.wtg_op = WTG_BEQ;
                ctl.reg_we = 1'b0;
            end
            6'b000101: begin
                ctl.wtg_op = WTG_BNE;
                ctl.reg_we = 1'b0;
            end
            6'b000110: begin
                ctl.wtg_op = WTG_BLEZ;
                ctl.reg_we = 1'b0;
            end
            6'b000111: begin
                ctl.wtg_op = WTG_BGTZ;
                ctl.reg_we = 1'b0;
            end

            6'b001000: ctl.alu_op = ALU_ADD;                // addi
            6'b001001: ctl.alu_op = ALU_ADD;                // addiu
            6'b001010: ctl.alu_op = ALU_SLT;
            6'b001011: ctl.alu_op = ALU_SLTU;
            6'b001100: begin                                // andi
                ctl.alu_op   = ALU_AND;
                ctl.aluy_sel = ALUY_EXTZ;
            end
            6'b001101: begin                                // ori
                ctl.alu_op   = ALU_OR;
                ctl.aluy_sel = ALUY_EXTZ;
            end
            6'b001110: begin                                // xori
                ctl.alu_op   = ALU_XOR;
                ctl.aluy_sel = ALUY_EXTZ;
            end
            6'b001111: ctl.alu_op = ALU_LUI;

            6'b010000: begin                                // cp0, selected by rs
                case (rs)
                    5'b00000: ctl.trap = TRAP_CP0;          // mfc0
                    5'b00100: begin                         // mtc0
                        ctl.trap   = TRAP_CP0;
                        ctl.reg_we = 1'b0;
                    end
                    5'b10000: ctl.trap = TRAP_ERET;
                    default: ;
                endcase
            end

            // loads: address only, data would arrive from outside
            6'b100000: begin
                ctl.alu_op = ALU_ADD;
                ctl.mem_re = 1'b1;
                ctl.dm_op  = DM_BYTE_S;
            end
            6'b100001: begin
                ctl.alu_op = ALU_ADD;
                ctl.mem_re = 1'b1;
                ctl.dm_op  = DM_HALF_S;
            end
            6'b100011: begin
                ctl.alu_op = ALU_ADD;
                ctl.mem_re = 1'b1;
                ctl.dm_op  = DM_WORD;
            end
            6'b100100: begin
                ctl.alu_op = ALU_ADD;
                ctl.mem_re = 1'b1;
                ctl.dm_op  = DM_BYTE_U;
            end
            6'b100101: begin
                ctl.alu_op = ALU_ADD;
                ctl.mem_re = 1'b1;
                ctl.dm_op  = DM_HALF_U;
            end

            6'b101000: begin                                // sb
                ctl.alu_op = ALU_ADD;
                ctl.mem_we = 1'b1;
                ctl.reg_we = 1'b0;
                ctl.dm_op  = DM_BYTE_S;
            end
            6'b101001: begin                                // sh
                ctl.alu_op = ALU_ADD;
                ctl.mem_we = 1'b1;
                ctl.reg_we = 1'b0;
                ctl.dm_op  = DM_HALF_S;
            end
            6'b101011: begin                                // sw
                ctl.alu_op = ALU_ADD;
                ctl.mem_we = 1'b1;
                ctl.reg_we = 1'b0;
                ctl.dm_op  = DM_WORD;
            end
            default: ;
        endcase
    end

endmodule

// File: src/exec_unit.sv
`timescale 1ns/1ps

module exec_unit import mips_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  word_t    pc,
    input  reg_idx_t rt,
    input  reg_idx_t rd,
    ctrl_if.exe      ctl,
    operand_if.exe   opnd,
    output logic     wb_we,
    output reg_idx_t wb_idx,
    output word_t    wb_data,
    output logic     out_valid,
    output word_t    next_pc,
    output logic     mem_re,
    output logic     mem_we,
    output word_t    mem_addr,
    output word_t    mem_wdata,
    output dm_op_t   mem_op,
    output trap_t    trap
);

    word_t    alu_y;
    word_t    alu_res;
    word_t    pc4;
    word_t    nxt_pc;
    word_t    wb_val;
    reg_idx_t dst_idx;
    logic     br_taken;
    logic     wr_ok;

    always_comb begin
        case (ctl.aluy_sel)
            ALUY_RT:   alu_y = opnd.rt_val;
            ALUY_EXTZ: alu_y = opnd.imm_z;
            default:   alu_y = opnd.imm_s;
        endcase
    end

    always_comb begin
        case (ctl.alu_op)
            ALU_AND:  alu_res = opnd.rs_val & alu_y;
            ALU_OR:   alu_res = opnd.rs_val | alu_y;
            ALU_XOR:  alu_res = opnd.rs_val ^ alu_y;
            ALU_NOR:  alu_res = ~(opnd.rs_val | alu_y);
            ALU_ADD:  alu_res = opnd.rs_val + alu_y;
            ALU_SUB:  alu_res = opnd.rs_val - alu_y;
            ALU_SLT:  alu_res = word_t'($signed(opnd.rs_val) < $signed(alu_y));
            ALU_SLTU: alu_res = word_t'(opnd.rs_val < alu_y);
            ALU_SLL:  alu_res = alu_y << opnd.shamt;
            ALU_SRL:  alu_res = alu_y >> opnd.shamt;
            ALU_SRA:  alu_res = $signed(alu_y) >>> opnd.shamt;
            ALU_SLLV: alu_res = alu_y << opnd.rs_val[4:0];
            ALU_SRLV: alu_res = alu_y >> opnd.rs_val[4:0];
            ALU_SRAV: alu_res = $signed(alu_y) >>> opnd.rs_val[4:0];
            ALU_LUI:  alu_res = {alu_y[15:0], 16'h0000};
            default:  alu_res = '0;
        endcase
    end

    always_comb begin
        case (ctl.wtg_op)
            WTG_BEQ:       br_taken = (opnd.rs_val == opnd.rt_val);
            WTG_BNE:       br_taken = (opnd.rs_val != opnd.rt_val);
            WTG_BLEZ:      br_taken = ($signed(opnd.rs_val) <= 0);
            WTG_BGTZ:      br_taken = ($signed(opnd.rs_val) > 0);
            WTG_BLTZ_BGEZ: br_taken = rt[0] ? !opnd.rs_val[31] : opnd.rs_val[31];
            default:       br_taken = 1'b0;
        endcase
    end

    assign pc4 = pc + 32'd4;

    always_comb begin
        case (ctl.wtg_op)
            WTG_J26: nxt_pc = {pc4[31:28], opnd.target26, 2'b00};
            WTG_J32: nxt_pc = opnd.rs_val;                          // jr
            default: nxt_pc = br_taken ? pc4 + {opnd.imm_s[29:0], 2'b00} : pc4;
        endcase
    end

    always_comb begin
        case (ctl.wreg_sel)
            WREG_RD:  dst_idx = rd;
            WREG_R31: dst_idx = 5'd31;
            default:  dst_idx = rt;
        endcase
    end

    assign wb_val = (ctl.wdata_sel == WDATA_PC4) ? pc4 : alu_res;
    assign wr_ok  = ctl.reg_we && !ctl.mem_re && (ctl.trap == TRAP_NONE);  // mfc0 stops here

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            wb_we     <= 1'b0;
            mem_re    <= 1'b0;
            mem_we    <= 1'b0;
            trap      <= TRAP_NONE;
            next_pc   <= '0;
        end else begin
            out_valid <= in_valid;
            wb_we     <= in_valid && wr_ok;
            mem_re    <= in_valid && ctl.mem_re;
            mem_we    <= in_valid && ctl.mem_we;
            trap      <= in_valid ? ctl.trap : TRAP_NONE;
            if (in_valid) next_pc <= nxt_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin             // payload holds while idle
            wb_idx    <= dst_idx;
            wb_data   <= wb_val;
            mem_addr  <= alu_res;
            mem_wdata <= opnd.rt_val;
            mem_op    <= ctl.dm_op;
        end
    end

endmodule

// File: src/mips_core_slice.sv
`timescale 1ns/1ps

module mips_core_slice import mips_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  word_t    instr,
    input  word_t    pc,
    output logic     out_valid,
    output word_t    next_pc,
    output logic     wb_we,
    output reg_idx_t wb_idx,
    output word_t    wb_data,
    output logic     mem_re,
    output logic     mem_we,
    output word_t    mem_addr,
    output word_t    mem_wdata,
    output dm_op_t   mem_op,
    output trap_t    trap
);

    logic [5:0]  opcode;
    reg_idx_t    rs;
    reg_idx_t    rt;
    reg_idx_t    rd;
    logic [4:0]  shamt;
    logic [5:0]  funct;
    logic [15:0] imm16;
    logic [25:0] target26;

    assign opcode   = instr[31:26];
    assign rs       = instr[25:21];
    assign rt       = instr[20:16];
    assign rd       = instr[15:11];
    assign shamt    = instr[10:6];
    assign funct    = instr[5:0];
    assign imm16    = instr[15:0];
    assign target26 = instr[25:0];

    ctrl_if    ctl_bus ();
    operand_if opnd_bus ();

    cmb_control cmb_control_inst (
        .opcode (opcode),
        .rs     (rs),
        .rt     (rt),
        .funct  (funct),
        .ctl    (ctl_bus.dec)
    );

    operand_fetch operand_fetch_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs       (rs),
        .rt       (rt),
        .imm16    (imm16),
        .shamt    (shamt),
        .target26 (target26),
        .wb_we    (wb_we),          // write-back loop, also on the ports
        .wb_idx   (wb_idx),
        .wb_data  (wb_data),
        .opnd     (opnd_bus.src)
    );

    exec_unit exec_unit_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .pc        (pc),
        .rt        (rt),
        .rd        (rd),
        .ctl       (ctl_bus.exe),
        .opnd      (opnd_bus.exe),
        .wb_we     (wb_we),
        .wb_idx    (wb_idx),
        .wb_data   (wb_data),
        .out_valid (out_valid),
        .next_pc   (next_pc),
        .mem_re    (mem_re),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_op    (mem_op),
        .trap      (trap)
    );

endmodule

// File: src/mips_ifs.sv
`timescale 1ns/1ps

interface ctrl_if import mips_pkg::*; ();

    alu_op_t    alu_op;
    wtg_op_t    wtg_op;
    dm_op_t     dm_op;
    logic       reg_we;
    logic       mem_we;
    logic       mem_re;
    wreg_sel_t  wreg_sel;
    wdata_sel_t wdata_sel;
    aluy_sel_t  aluy_sel;
    trap_t      trap;

    modport dec (
        output alu_op, wtg_op, dm_op, reg_we, mem_we, mem_re,
        output wreg_sel, wdata_sel, aluy_sel, trap
    );

    modport exe (
        input alu_op, wtg_op, dm_op, reg_we, mem_we, mem_re,
        input wreg_sel, wdata_sel, aluy_sel, trap
    );

endinterface

interface operand_if import mips_pkg::*; ();

    word_t       rs_val;
    word_t       rt_val;
    word_t       imm_s;     // sign extended imm16
    word_t       imm_z;     // zero extended imm16
    logic [4:0]  shamt;
    logic [25:0] target26;

    modport src (
        output rs_val, rt_val, imm_s, imm_z, shamt, target26
    );

    modport exe (
        input rs_val, rt_val, imm_s, imm_z, shamt, target26
    );

endinterface

// File: src/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// data path and register file sizing
`define MIPS_WORD_W     32
`define MIPS_REG_N      32

// control field widths
`define MIPS_ALU_OP_W   4
`define MIPS_WTG_OP_W   3   // next pc selection
`define MIPS_DM_OP_W    3   // access size
`define MIPS_TRAP_W     2

`endif

// File: src/mips_pkg.sv
`include "mips_macros.svh"

package mips_pkg;

    typedef logic [`MIPS_WORD_W-1:0]         word_t;
    typedef logic [$clog2(`MIPS_REG_N)-1:0]  reg_idx_t;
    typedef logic [`MIPS_ALU_OP_W-1:0]       alu_op_t;
    typedef logic [`MIPS_WTG_OP_W-1:0]       wtg_op_t;
    typedef logic [`MIPS_DM_OP_W-1:0]        dm_op_t;
    typedef logic [1:0]                      wreg_sel_t;
    typedef logic                            wdata_sel_t;
    typedef logic [1:0]                      aluy_sel_t;
    typedef logic [`MIPS_TRAP_W-1:0]         trap_t;

    localparam alu_op_t ALU_AND  = 4'd0;
    localparam alu_op_t ALU_OR   = 4'd1;
    localparam alu_op_t ALU_XOR  = 4'd2;
    localparam alu_op_t ALU_NOR  = 4'd3;
    localparam alu_op_t ALU_ADD  = 4'd4;
    localparam alu_op_t ALU_SUB  = 4'd5;
    localparam alu_op_t ALU_SLT  = 4'd6;
    localparam alu_op_t ALU_SLTU = 4'd7;
    localparam alu_op_t ALU_SLL  = 4'd8;    // by shamt
    localparam alu_op_t ALU_SRL  = 4'd9;
    localparam alu_op_t ALU_SRA  = 4'd10;
    localparam alu_op_t ALU_SLLV = 4'd11;   // by rs[4:0]
    localparam alu_op_t ALU_SRLV = 4'd12;
    localparam alu_op_t ALU_SRAV = 4'd13;
    localparam alu_op_t ALU_LUI  = 4'd14;

    localparam wtg_op_t WTG_PC4       = 3'd0;
    localparam wtg_op_t WTG_J26       = 3'd1;
    localparam wtg_op_t WTG_J32       = 3'd2;
    localparam wtg_op_t WTG_BEQ       = 3'd3;
    localparam wtg_op_t WTG_BNE       = 3'd4;
    localparam wtg_op_t WTG_BLEZ      = 3'd5;
    localparam wtg_op_t WTG_BGTZ      = 3'd6;
    localparam wtg_op_t WTG_BLTZ_BGEZ = 3'd7;  // rt[0] picks bgez

    localparam dm_op_t DM_WORD   = 3'd0;
    localparam dm_op_t DM_HALF_S = 3'd1;
    localparam dm_op_t DM_HALF_U = 3'd2;
    localparam dm_op_t DM_BYTE_S = 3'd3;
    localparam dm_op_t DM_BYTE_U = 3'd4;

    localparam wreg_sel_t WREG_RT  = 2'd0;
    localparam wreg_sel_t WREG_RD  = 2'd1;
    localparam wreg_sel_t WREG_R31 = 2'd2;

    localparam wdata_sel_t WDATA_ALU = 1'b0;
    localparam wdata_sel_t WDATA_PC4 = 1'b1;

    localparam aluy_sel_t ALUY_RT   = 2'd0;
    localparam aluy_sel_t ALUY_EXTS = 2'd1;
    localparam aluy_sel_t ALUY_EXTZ = 2'd2;

    localparam trap_t TRAP_NONE    = 2'd0;
    localparam trap_t TRAP_SYSCALL = 2'd1;
    localparam trap_t TRAP_CP0     = 2'd2;  // mfc0 and mtc0
    localparam trap_t TRAP_ERET    = 2'd3;

endpackage

// File: src/operand_fetch.sv
`timescale 1ns/1ps

`include "mips_macros.svh"

module operand_fetch import mips_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  reg_idx_t    rs,
    input  reg_idx_t    rt,
    input  logic [15:0] imm16,
    input  logic [4:0]  shamt,
    input  logic [25:0] target26,
    input  logic        wb_we,
    input  reg_idx_t    wb_idx,
    input  word_t       wb_data,
    operand_if.src      opnd
);

    word_t regs [`MIPS_REG_N];
    logic  wb_live;     // write in flight, not yet in regs
    logic  fwd_rs;
    logic  fwd_rt;

    // result stage holds the write for one cycle, so it lands one edge later
    assign wb_live = wb_we && (wb_idx != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `MIPS_REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_live) begin
            regs[wb_idx] <= wb_data;                // r0 writes dropped
        end
    end

    assign fwd_rs = wb_live && (wb_idx == rs);
    assign fwd_rt = wb_live && (wb_idx == rt);

    always_comb begin
        if (rs == '0) opnd.rs_val = '0;
        else if (fwd_rs) opnd.rs_val = wb_data;
        else opnd.rs_val = regs[rs];

        if (rt == '0) opnd.rt_val = '0;
        else if (fwd_rt) opnd.rt_val = wb_data;
        else opnd.rt_val = regs[rt];
    end

    assign opnd.imm_s    = {{16{imm16[15]}}, imm16};
    assign opnd.imm_z    = {16'h0000, imm16};
    assign opnd.shamt    = shamt;
    assign opnd.target26 = target26;

endmodule

// File: tests/mips_core_slice_sva.sv
`timescale 1ns/1ps

module mips_core_slice_sva (
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic out_valid,
    input logic wb_we,
    input logic mem_re,
    input logic mem_we
);

    logic seen_edge = 1'b0;     // no history before the first edge

    always @(posedge clk) begin
        seen_edge <= 1'b1;
    end

    valid_follows: assert property (@(posedge clk)
        seen_edge && $past(rst_n) |-> out_valid == $past(in_valid))
        else $error("out_valid does not follow in_valid by one cycle");

    mem_excl: assert property (@(posedge clk) seen_edge |-> !(mem_re && mem_we))
        else $error("mem_re and mem_we high in the same cycle");

    // covers the reset cycles and the first cycle after release
    quiet_in_reset: assert property (@(posedge clk)
        seen_edge && !$past(rst_n) |-> !wb_we && !mem_re && !mem_we)
        else $error("write or memory strobe active during or right after reset");

endmodule

bind mips_core_slice mips_core_slice_sva mips_core_slice_sva_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .wb_we     (wb_we),
    .mem_re    (mem_re),
    .mem_we    (mem_we)
);

// File: tests/mips_core_slice_tb.sv
`timescale 1ns/1ps

`include "mips_macros.svh"

module mips_core_slice_tb import mips_pkg::*; ();

    localparam int N_TESTS     = 600;
    localparam int RST_CYCLES  = 5;
    localparam int N_ENC       = 44;
    localparam int WATCHDOG_NS = (N_TESTS + RST_CYCLES + 50) * 4;

    // legal encodings, free fields are filled at random
    localparam word_t ENC_TAB [N_ENC] = '{
        32'h0000_0000, 32'h0000_0002, 32'h0000_0003, 32'h0000_0004, 32'h0000_0006,
        32'h0000_0007, 32'h0000_0008, 32'h0000_000C, 32'h0000_0020, 32'h0000_0021,
        32'h0000_0022, 32'h0000_0023, 32'h0000_0024, 32'h0000_0025, 32'h0000_0026,
        32'h0000_0027, 32'h0000_002A, 32'h0000_002B, 32'h0400_0000, 32'h0800_0000,
        32'h0C00_0000, 32'h1000_0000, 32'h1400_0000, 32'h1800_0000, 32'h1C00_0000,
        32'h2000_0000, 32'h2400_0000, 32'h2800_0000, 32'h2C00_0000, 32'h3000_0000,
        32'h3400_0000, 32'h3800_0000, 32'h3C00_0000, 32'h4000_0000, 32'h4080_0000,
        32'h4200_0000, 32'h8000_0000, 32'h8400_0000, 32'h8C00_0000, 32'h9000_0000,
        32'h9400_0000, 32'hA000_0000, 32'hA400_0000, 32'hAC00_0000
    };

    typedef struct packed {
        logic     valid;
        logic     we;
        reg_idx_t idx;
        word_t    data;
        word_t    npc;
        logic     re;
        logic     wr;
        word_t    addr;
        word_t    wdata;
        dm_op_t   op;
        trap_t    trap;
    } exp_t;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     in_valid;
    word_t    instr;
    word_t    pc;
    logic     out_valid;
    word_t    next_pc;
    logic     wb_we;
    reg_idx_t wb_idx;
    word_t    wb_data;
    logic     mem_re;
    logic     mem_we;
    word_t    mem_addr;
    word_t    mem_wdata;
    dm_op_t   mem_op;
    trap_t    trap;

    integer seed;
    word_t  mreg [`MIPS_REG_N] = '{default: '0};   // register file model
    exp_t   pend;                                   // expectation for the cycle in flight
    word_t  hold_npc;

    mips_core_slice mips_core_slice_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .instr     (instr),
        .pc        (pc),
        .out_valid (out_valid),
        .next_pc   (next_pc),
        .wb_we     (wb_we),
        .wb_idx    (wb_idx),
        .wb_data   (wb_data),
        .mem_re    (mem_re),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_op    (mem_op),
        .trap      (trap)
    );

    always #2 clk = ~clk;

    function automatic reg_idx_t pick_reg();
        integer r;
        r = $random(seed);
        pick_reg = r[7] ? {3'b000, r[1:0]} : r[12:8];     // low registers get reused often
    endfunction

    function automatic word_t fixed_bits(input logic [5:0] op);
        case (op)
            6'h00:   fixed_bits = 32'hFC00_003F;   // opcode and funct
            6'h01:   fixed_bits = 32'hFC1E_0000;   // rt limited to bltz and bgez
            6'h10:   fixed_bits = 32'hFFE0_0000;   // rs picks the cp0 operation
            default: fixed_bits = 32'hFC00_0000;
        endcase
    endfunction

    function automatic word_t gen_instr();
        logic [5:0] sel;
        word_t      tmpl;
        word_t      raw;
        word_t      mask;
        integer     r;
        sel  = 6'({$random(seed)} % N_ENC);
        tmpl = ENC_TAB[sel];
        r    = $random(seed);
        raw  = {6'b000000, pick_reg(), pick_reg(), r[15:0]};
        if (tmpl[31:26] == 6'h00) raw[15:11] = pick_reg();
        mask = fixed_bits(tmpl[31:26]);
        gen_instr = (raw & ~mask) | (tmpl & mask);
    endfunction

    function automatic dm_op_t size_of(input logic [5:0] op);
        case (op[2:0])
            3'd0:    size_of = DM_BYTE_S;
            3'd1:    size_of = DM_HALF_S;
            3'd4:    size_of = DM_BYTE_U;
            3'd5:    size_of = DM_HALF_U;
            default: size_of = DM_WORD;
        endcase
    endfunction

    function automatic exp_t idle_exp(input word_t npc);
        exp_t e;
        e      = '0;
        e.npc  = npc;
        e.trap = TRAP_NONE;
        return e;
    endfunction

    function automatic exp_t predict(input word_t ins, input word_t pcv);
        exp_t       e;
        logic [5:0] op;
        logic [5:0] fn;
        reg_idx_t   rs;
        reg_idx_t   rt;
        logic [4:0] sh;
        word_t      a;
        word_t      b;
        word_t      ims;
        word_t      imz;
        word_t      pc4;
        logic       taken;
        op      = ins[31:26];
        fn      = ins[5:0];
        rs      = ins[25:21];
        rt      = ins[20:16];
        sh      = ins[10:6];
        a       = (rs == '0) ? '0 : mreg[rs];
        b       = (rt == '0) ? '0 : mreg[rt];
        ims     = {{16{ins[15]}}, ins[15:0]};
        imz     = {16'h0000, ins[15:0]};
        pc4     = pcv + 32'd4;
        taken   = 1'b0;
        e       = '0;
        e.valid = 1'b1;
        e.we    = 1'b1;
        e.idx   = rt;
        e.npc   = pc4;
        e.op    = DM_WORD;
        e.trap  = TRAP_NONE;
        case (op)
            6'h00: begin
                e.idx = ins[15:11];
                case (fn)
                    6'h00:        e.data = b << sh;
                    6'h02:        e.data = b >> sh;
                    6'h03:        e.data = $signed(b) >>> sh;
                    6'h04:        e.data = b << a[4:0];
                    6'h06:        e.data = b >> a[4:0];
                    6'h07:        e.data = $signed(b) >>> a[4:0];
                    6'h08: begin                        // jr
                        e.we  = 1'b0;
                        e.npc = a;
                    end
                    6'h0C: begin
                        e.we   = 1'b0;
                        e.trap = TRAP_SYSCALL;
                    end
                    6'h20, 6'h21: e.data = a + b;
                    6'h22, 6'h23: e.data = a - b;
                    6'h24:        e.data = a & b;
                    6'h25:        e.data = a | b;
                    6'h26:        e.data = a ^ b;
                    6'h27:        e.data = ~(a | b);
                    6'h2A:        e.data = {31'b0, $signed(a) < $signed(b)};
                    6'h2B:        e.data = {31'b0, a < b};
                    default: ;
                endcase
            end
            6'h01: begin
                e.we  = 1'b0;
                taken = rt[0] ? !a[31] : a[31];
            end
            6'h02: begin
                e.we  = 1'b0;
                e.npc = {pc4[31:28], ins[25:0], 2'b00};
            end
            6'h03: begin                                // jal links into r31
                e.idx  = 5'd31;
                e.data = pc4;
                e.npc  = {pc4[31:28], ins[25:0], 2'b00};
            end
            6'h04: begin
                e.we  = 1'b0;
                taken = (a == b);
            end
            6'h05: begin
                e.we  = 1'b0;
                taken = (a != b);
            end
            6'h06: begin
                e.we  = 1'b0;
                taken = a[31] || (a == '0);
            end
            6'h07: begin
                e.we  = 1'b0;
                taken = !a[31] && (a != '0);
            end
            6'h08, 6'h09: e.data = a + ims;
            6'h0A: e.data = {31'b0, $signed(a) < $signed(ims)};
            6'h0B: e.data = {31'b0, a < ims};
            6'h0C: e.data = a & imz;
            6'h0D: e.data = a | imz;
            6'h0E: e.data = a ^ imz;
            6'h0F: e.data = {ins[15:0], 16'h0000};
            6'h10: begin
                e.we   = 1'b0;
                e.trap = (rs == 5'd16) ? TRAP_ERET : TRAP_CP0;
            end
            6'h20, 6'h21, 6'h23, 6'h24, 6'h25: begin
                e.we   = 1'b0;
                e.re   = 1'b1;
                e.addr = a + ims;
                e.op   = size_of(op);
            end
            6'h28, 6'h29, 6'h2B: begin
                e.we    = 1'b0;
                e.wr    = 1'b1;
                e.addr  = a + ims;
                e.wdata = b;
                e.op    = size_of(op);
            end
            default: ;
        endcase
        if (taken) e.npc = pc4 + {ims[29:0], 2'b00};
        if (e.we && e.idx != '0) mreg[e.idx] = e.data;
        return e;
    endfunction

    task automatic stop_on_error();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_bit(input string what, input logic got, input logic want);
        if (got !== want) begin
            $display("FAIL at %0t ns: %s is %b, expected %b", $time, what, got, want);
            stop_on_error();
        end
    endtask

    task automatic check_word(input string what, input word_t got, input word_t want);
        if (got !== want) begin
            $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, want);
            stop_on_error();
        end
    endtask

    task automatic check_idx(input string what, input reg_idx_t got, input reg_idx_t want);
        if (got !== want) begin
            $display("FAIL at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
            stop_on_error();
        end
    endtask

    task automatic check_dm(input string what, input dm_op_t got, input dm_op_t want);
        if (got !== want) begin
            $display("FAIL at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
            stop_on_error();
        end
    endtask

    task automatic check_trap(input string what, input trap_t got, input trap_t want);
        if (got !== want) begin
            $display("FAIL at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
            stop_on_error();
        end
    endtask

    task automatic check_outputs(input exp_t want);
        check_bit("out_valid", out_valid, want.valid);
        check_bit("wb_we", wb_we, want.we);
        check_bit("mem_re", mem_re, want.re);
        check_bit("mem_we", mem_we, want.wr);
        check_trap("trap", trap, want.trap);
        check_word("next_pc", next_pc, want.npc);
        if (want.we) begin
            check_idx("wb_idx", wb_idx, want.idx);
            check_word("wb_data", wb_data, want.data);
        end
        if (want.re || want.wr) begin
            check_word("mem_addr", mem_addr, want.addr);
            check_dm("mem_op", mem_op, want.op);
        end
        if (want.wr) check_word("mem_wdata", mem_wdata, want.wdata);
    endtask

    initial begin : stimulus
        seed     = 32'h6319_66d2;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        instr    = '0;
        pc       = '0;
        hold_npc = '0;
        pend     = idle_exp(hold_npc);
        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        for (int n = 0; n < N_TESTS; n++) begin
            if (($random(seed) & 7) == 0) begin     // idle slot now and then
                in_valid = 1'b0;
                instr    = $random(seed);
                pend     = idle_exp(hold_npc);
            end else begin
                instr    = gen_instr();
                pc       = {$random(seed)} & 32'hFFFF_FFFC;
                in_valid = 1'b1;
                pend     = predict(instr, pc);
                hold_npc = pend.npc;
            end
            @(negedge clk);
        end
        in_valid = 1'b0;
        pend     = idle_exp(hold_npc);
        repeat (3) @(negedge clk);
        @(posedge clk);
        $display("PASS: all tests");
        $finish;
    end

    // results of the cycle before show up after the next rising edge
    initial begin : compare
        exp_t want;
        forever begin
            @(posedge clk);
            want = pend;
            @(negedge clk);
            check_outputs(want);
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout, the simulation did not finish in the expected time");
        stop_on_error();
    end

endmodule
